//--- src/gemm_macros.svh
`ifndef GEMM_MACROS_SVH
`define GEMM_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Tile geometry.
////////////////////////////////////////////////////////////////////////////

`define GEMM_TILE 8
`define GEMM_WORD_W 32
`define GEMM_BEAT_W 256

////////////////////////////////////////////////////////////////////////////
// APB register map.
////////////////////////////////////////////////////////////////////////////

`define GEMM_REG_CTRL   32'h000
`define GEMM_REG_STATUS 32'h004
`define GEMM_REG_BASE_A 32'h008
`define GEMM_REG_BASE_B 32'h00C
`define GEMM_REG_K      32'h010
`define GEMM_REG_C_BASE 32'h100 // 64 result words up to 0x1FC.

`endif

//--- src/gemm_pkg.sv
`include "gemm_macros.svh"

package gemm_pkg;

    typedef logic [`GEMM_WORD_W-1:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [`GEMM_BEAT_W-1:0] beat_t;
    typedef logic [15:0] depth_t;

    // Run configuration from the host.
    typedef struct packed {
        addr_t  base_a;
        addr_t  base_b;
        depth_t k;
    } cfg_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_req_t;

    // One k step, A column and B row.
    typedef struct packed {
        logic  valid;
        beat_t a_beat;
        beat_t b_beat;
    } step_t;

    typedef word_t [`GEMM_TILE-1:0] row_acc_t; // One row of C.

    typedef enum logic [2:0] {
        IDLE,
        REQ_A,
        WAIT_A,
        REQ_B,
        WAIT_B,
        FINISH
    } load_state_e;

endpackage

//--- src/gemm_apb_regs.sv
`timescale 1ns/1ps
`include "gemm_macros.svh"

module gemm_apb_regs (
    input  logic                clk,
    input  logic                rstn,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  gemm_pkg::addr_t     paddr,
    input  gemm_pkg::word_t     pwdata,
    output gemm_pkg::word_t     prdata,
    output logic                pready,
    output logic                pslverr,
    output gemm_pkg::cfg_t      cfg,
    output logic                start,
    input  logic                finish,
    output logic [5:0]          res_index,
    input  gemm_pkg::word_t     res_word
);

    logic access;
    logic wr;
    logic is_ctrl, is_status, is_base_a, is_base_b, is_k, is_result;
    logic mapped;
    logic busy_q;
    logic done_q;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode.
    ////////////////////////////////////////////////////////////////////////////

    assign is_ctrl   = paddr == `GEMM_REG_CTRL;
    assign is_status = paddr == `GEMM_REG_STATUS;
    assign is_base_a = paddr == `GEMM_REG_BASE_A;
    assign is_base_b = paddr == `GEMM_REG_BASE_B;
    assign is_k      = paddr == `GEMM_REG_K;
    assign is_result = (paddr & ~gemm_pkg::addr_t'(32'hFC)) == `GEMM_REG_C_BASE;
    assign mapped    = is_ctrl | is_status | is_base_a | is_base_b | is_k | is_result;

    assign access    = psel & penable;
    assign wr        = access & pwrite;
    assign pready    = 1'b1; // No wait states.
    assign pslverr   = access & ~mapped;
    assign res_index = paddr[7:2];

    assign start = wr & is_ctrl & pwdata[0] & ~busy_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg <= '0;
        end else if (wr) begin
            if (is_base_a) cfg.base_a <= pwdata;
            if (is_base_b) cfg.base_b <= pwdata;
            if (is_k) cfg.k <= pwdata[15:0];
        end
    end

    // Busy from start to finish, done until the next start.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (finish) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
        end
    end

    always_comb begin
        prdata = '0;
        if (is_status) prdata = gemm_pkg::word_t'({done_q, busy_q});
        else if (is_base_a) prdata = cfg.base_a;
        else if (is_base_b) prdata = cfg.base_b;
        else if (is_k) prdata = gemm_pkg::word_t'(cfg.k);
        else if (is_result) prdata = res_word;
    end

    // Finish only ends a run that is in progress.
    a_finish_busy: assert property (@(posedge clk) disable iff (!rstn)
        finish |-> busy_q);

endmodule

//--- src/gemm_tile_loader.sv
`timescale 1ns/1ps
`include "gemm_macros.svh"

module gemm_tile_loader (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start,
    input  gemm_pkg::cfg_t       cfg,
    output gemm_pkg::mem_req_t   mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  gemm_pkg::beat_t      mem_rsp_data,
    output gemm_pkg::step_t      step,
    output logic                 clear,
    output logic                 finish
);

    gemm_pkg::load_state_e state;
    gemm_pkg::addr_t       addr_a;
    gemm_pkg::addr_t       addr_b;
    gemm_pkg::depth_t      k_q;
    gemm_pkg::depth_t      step_cnt;
    gemm_pkg::beat_t       a_q;
    gemm_pkg::beat_t       b_q;
    logic                  step_valid;
    logic                  fin_arm;
    logic                  last_step;

    assign last_step = step_cnt == k_q - gemm_pkg::depth_t'(1);

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= gemm_pkg::IDLE;
            step_cnt   <= '0;
            step_valid <= 1'b0;
            clear      <= 1'b0;
            fin_arm    <= 1'b0;
            finish     <= 1'b0;
        end else begin
            step_valid <= 1'b0;
            clear      <= 1'b0;
            fin_arm    <= 1'b0;
            finish     <= fin_arm; // Extra cycle lets the last sum land.
            case (state)
                gemm_pkg::IDLE: begin
                    if (start) begin
                        clear    <= 1'b1;
                        step_cnt <= '0;
                        if (cfg.k == '0) fin_arm <= 1'b1; // Empty run.
                        else state <= gemm_pkg::REQ_A;
                    end
                end
                gemm_pkg::REQ_A: begin
                    if (mem_req_ready) state <= gemm_pkg::WAIT_A;
                end
                gemm_pkg::WAIT_A: begin
                    if (mem_rsp_valid) state <= gemm_pkg::REQ_B;
                end
                gemm_pkg::REQ_B: begin
                    if (mem_req_ready) state <= gemm_pkg::WAIT_B;
                end
                gemm_pkg::WAIT_B: begin
                    if (mem_rsp_valid) begin
                        step_valid <= 1'b1;
                        step_cnt   <= step_cnt + gemm_pkg::depth_t'(1);
                        state      <= last_step ? gemm_pkg::FINISH : gemm_pkg::REQ_A;
                    end
                end
                gemm_pkg::FINISH: begin
                    fin_arm <= 1'b1;
                    state   <= gemm_pkg::IDLE;
                end
                default: state <= gemm_pkg::IDLE;
            endcase
        end
    end

    // Addresses and beat holding.
    always_ff @(posedge clk) begin
        if (state == gemm_pkg::IDLE && start) begin
            addr_a <= cfg.base_a;
            addr_b <= cfg.base_b;
            k_q    <= cfg.k;
        end
        if (state == gemm_pkg::WAIT_A && mem_rsp_valid) a_q <= mem_rsp_data;
        if (state == gemm_pkg::WAIT_B && mem_rsp_valid) begin
            b_q    <= mem_rsp_data;
            addr_a <= addr_a + gemm_pkg::addr_t'(`GEMM_BEAT_W / 8);
            addr_b <= addr_b + gemm_pkg::addr_t'(`GEMM_BEAT_W / 8);
        end
    end

    always_comb begin
        mem_req.valid = state == gemm_pkg::REQ_A || state == gemm_pkg::REQ_B;
        mem_req.addr  = (state == gemm_pkg::REQ_A) ? addr_a : addr_b;
    end

    assign step.valid  = step_valid;
    assign step.a_beat = a_q;
    assign step.b_beat = b_q;

    a_addr_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req.valid && !mem_req_ready |=> mem_req.valid && $stable(mem_req.addr));

endmodule

//--- src/gemm_mac_row.sv
`timescale 1ns/1ps
`include "gemm_macros.svh"

module gemm_mac_row #(
    parameter int ROW = 0
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 clear,
    input  gemm_pkg::step_t      step,
    output gemm_pkg::row_acc_t   acc
);

    gemm_pkg::word_t a_elem;

    assign a_elem = step.a_beat[ROW*`GEMM_WORD_W +: `GEMM_WORD_W]; // A[ROW][kk].

    // Outer product row: acc[j] += A[ROW][kk] * B[kk][j], mod 2^32.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (step.valid) begin
            for (int j = 0; j < `GEMM_TILE; j++) begin
                acc[j] <= acc[j] + a_elem * step.b_beat[j*`GEMM_WORD_W +: `GEMM_WORD_W];
            end
        end
    end

    // The loader never sends a step in the cycle it clears.
    a_no_clear_step: assert property (@(posedge clk) disable iff (!rstn)
        !(clear && step.valid));

endmodule

//--- src/gemm_result_drain.sv
`timescale 1ns/1ps
`include "gemm_macros.svh"

module gemm_result_drain (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 finish,
    input  gemm_pkg::row_acc_t   rows [`GEMM_TILE],
    input  logic [5:0]           res_index,
    output gemm_pkg::word_t      res_word
);

    gemm_pkg::row_acc_t store_q [`GEMM_TILE];
    logic [2:0]         row_sel;
    logic [2:0]         col_sel;

    assign row_sel = res_index[5:3];
    assign col_sel = res_index[2:0];

    // Snapshot of the finished tile, kept until the next finish.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `GEMM_TILE; i++) begin
                store_q[i] <= '0;
            end
        end else if (finish) begin
            store_q <= rows;
        end
    end

    assign res_word = store_q[row_sel][col_sel]; // C[i][j] at i*8+j.

endmodule

//--- src/gemm_top.sv
`timescale 1ns/1ps
`include "gemm_macros.svh"

module gemm_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  gemm_pkg::addr_t      paddr,
    input  gemm_pkg::word_t      pwdata,
    output gemm_pkg::word_t      prdata,
    output logic                 pready,
    output logic                 pslverr,
    output gemm_pkg::mem_req_t   mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  gemm_pkg::beat_t      mem_rsp_data
);

    gemm_pkg::cfg_t     cfg;
    gemm_pkg::step_t    step;
    gemm_pkg::word_t    res_word;
    gemm_pkg::row_acc_t rows [`GEMM_TILE];
    logic               start;
    logic               clear;
    logic               finish;
    logic [5:0]         res_index;

    gemm_apb_regs regs_inst (
        .clk       (clk),
        .rstn      (rstn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cfg       (cfg),
        .start     (start),
        .finish    (finish),
        .res_index (res_index),
        .res_word  (res_word)
    );

    gemm_tile_loader loader_inst (
        .clk           (clk),
        .rstn          (rstn),
        .start         (start),
        .cfg           (cfg),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .step          (step),
        .clear         (clear),
        .finish        (finish)
    );

    ////////////////////////////////////////////////////////////////////////////
    // One MAC row per output row.
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `GEMM_TILE; i++) begin : g_row
        gemm_mac_row #(.ROW(i)) row_inst (
            .clk   (clk),
            .rstn  (rstn),
            .clear (clear),
            .step  (step),
            .acc   (rows[i])
        );
    end

    gemm_result_drain drain_inst (
        .clk       (clk),
        .rstn      (rstn),
        .finish    (finish),
        .rows      (rows),
        .res_index (res_index),
        .res_word  (res_word)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period.
    end

    // Reset held for 16 cycles, released on a falling edge.
    initial begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

//--- tb/tb_gemm_top.sv
`timescale 1ns/1ps
`include "gemm_macros.svh"

module tb_gemm_top;

    localparam int K_BUDGET       = 5 + 8 + 3 * 12 + 6; // Worst case k over all runs.
    localparam int TIMEOUT_CYCLES = 200 * K_BUDGET + 2000;
    localparam int MEM_WORDS      = 4096;

    logic               clk;
    logic               rstn;
    logic               psel;
    logic               penable;
    logic               pwrite;
    gemm_pkg::addr_t    paddr;
    gemm_pkg::word_t    pwdata;
    gemm_pkg::word_t    prdata;
    logic               pready;
    logic               pslverr;
    gemm_pkg::mem_req_t mem_req;
    logic               mem_req_ready;
    logic               mem_rsp_valid;
    gemm_pkg::beat_t    mem_rsp_data;

    gemm_pkg::word_t    mem [MEM_WORDS];
    gemm_pkg::word_t    exp_c [64];
    gemm_pkg::word_t    prev_c [64];
    logic [31:0]        stim_rng;
    logic               throttle;
    int                 errors;
    int                 test_errors;
    int                 tests_passed;
    int                 tests_failed;
    int                 cycle_cnt;

    tb_clock_gen clock_gen_inst (
        .clk  (clk),
        .rstn (rstn)
    );

    gemm_top gemm_top_inst (
        .clk           (clk),
        .rstn          (rstn),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 32-byte aligned, so twelve beats stay inside the model memory.
    function automatic gemm_pkg::addr_t random_base();
        stim_rng = xorshift(stim_rng);
        return gemm_pkg::addr_t'((stim_rng % 500) * 32);
    endfunction

    function automatic gemm_pkg::beat_t read_beat(input gemm_pkg::addr_t a);
        gemm_pkg::beat_t b;
        for (int w = 0; w < `GEMM_TILE; w++) begin
            b[w*`GEMM_WORD_W +: `GEMM_WORD_W] = mem[a[13:2] + w];
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Memory model.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : memory_model
        logic            xfer_pend;
        logic            stall_pend;
        gemm_pkg::addr_t req_addr;
        gemm_pkg::addr_t rsp_addr;
        int              rsp_wait;
        logic [31:0]     mem_rng;
        xfer_pend     = 1'b0;
        stall_pend    = 1'b0;
        req_addr      = '0;
        rsp_addr      = '0;
        rsp_wait      = 0;
        mem_rng       = xorshift(xorshift(32'ha855));
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever begin
            @(negedge clk);
            mem_rsp_valid = 1'b0;
            if (stall_pend && (!mem_req.valid || mem_req.addr !== req_addr)) begin
                $display("Memory request changed during a stall: 0x%h became 0x%h",
                         req_addr, mem_req.addr);
                errors++;
            end
            if (xfer_pend) begin // Accepted at the last rising edge.
                mem_rng  = xorshift(mem_rng);
                rsp_addr = req_addr;
                rsp_wait = throttle ? 1 + int'(mem_rng % 4) : 1;
            end
            if (rsp_wait > 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = read_beat(rsp_addr);
                end
            end
            mem_rng       = xorshift(mem_rng);
            mem_req_ready = throttle ? mem_rng[7] : 1'b1;
            xfer_pend     = mem_req.valid && mem_req_ready;
            stall_pend    = mem_req.valid && !mem_req_ready;
            req_addr      = mem_req.addr;
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB driver and checks.
    ////////////////////////////////////////////////////////////////////////////

    // Called on a falling edge, returns on a falling edge.
    task automatic apb_write(input gemm_pkg::addr_t addr, input gemm_pkg::word_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        if (pready !== 1'b1) begin
            $display("APB write to 0x%h did not complete in its access phase", addr);
            errors++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input gemm_pkg::addr_t addr, output gemm_pkg::word_t data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata; // Stable until the next rising edge.
        err  = pslverr;
        if (pready !== 1'b1) begin
            $display("APB read of 0x%h did not complete in its access phase", addr);
            errors++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_word(input string name, input gemm_pkg::word_t exp,
                              input gemm_pkg::word_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input logic [1:0] exp,
                                input logic [1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // Random A and B beats, then C[i][j] = sum of A[i][kk] * B[kk][j].
    task automatic fill_and_model(input gemm_pkg::addr_t base_a, input gemm_pkg::addr_t base_b,
                                  input int k);
        gemm_pkg::word_t a_elem;
        gemm_pkg::word_t b_elem;
        for (int w = 0; w < k * `GEMM_TILE; w++) begin
            stim_rng = xorshift(stim_rng);
            mem[base_a[13:2] + w] = stim_rng;
            stim_rng = xorshift(stim_rng);
            mem[base_b[13:2] + w] = stim_rng;
        end
        for (int i = 0; i < `GEMM_TILE; i++) begin
            for (int j = 0; j < `GEMM_TILE; j++) begin
                exp_c[i*8+j] = '0;
                for (int kk = 0; kk < k; kk++) begin
                    a_elem = mem[base_a[13:2] + kk*8 + i];
                    b_elem = mem[base_b[13:2] + kk*8 + j];
                    exp_c[i*8+j] = exp_c[i*8+j] + a_elem * b_elem;
                end
            end
        end
    endtask

    task automatic run_gemm(input string name, input gemm_pkg::addr_t base_a,
                            input gemm_pkg::addr_t base_b, input int k, input logic restart);
        gemm_pkg::word_t rd;
        logic            err;
        int              idx;
        fill_and_model(base_a, base_b, k);
        apb_write(`GEMM_REG_BASE_A, base_a);
        apb_write(`GEMM_REG_BASE_B, base_b);
        apb_write(`GEMM_REG_K, gemm_pkg::word_t'(k));
        apb_write(`GEMM_REG_CTRL, 32'h1);
        apb_read(`GEMM_REG_STATUS, rd, err);
        check_status({name, " busy"}, 2'b01, rd[1:0]);
        if (k > 0) begin // Old tile still visible mid-run.
            stim_rng = xorshift(stim_rng);
            idx = int'(stim_rng % 64);
            apb_read(`GEMM_REG_C_BASE + 4 * idx, rd, err);
            check_word($sformatf("%s held C[%0d]", name, idx), prev_c[idx], rd);
        end
        if (restart) begin
            apb_write(`GEMM_REG_CTRL, 32'h1);
        end
        do begin
            apb_read(`GEMM_REG_STATUS, rd, err);
        end while (rd[0] === 1'b1);
        check_status({name, " done"}, 2'b10, rd[1:0]);
        for (int n = 0; n < 64; n++) begin
            apb_read(`GEMM_REG_C_BASE + 4 * n, rd, err);
            check_word($sformatf("%s C[%0d]", name, n), exp_c[n], rd);
            if (err) begin
                $display("%s: the read of C[%0d] raised pslverr", name, n);
                errors++;
            end
        end
        prev_c = exp_c;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        gemm_pkg::word_t rd;
        logic            err;
        int              k;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        throttle     = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        stim_rng     = 32'ha855;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[15:0] ^ 16'hA5C3, ~i[15:0]};
        end
        for (int n = 0; n < 64; n++) begin
            prev_c[n] = '0;
        end
        @(posedge rstn); // Released on a falling edge.

        apb_read(`GEMM_REG_STATUS, rd, err);
        check_status("reset_status", 2'b00, rd[1:0]);
        if (err) begin
            $display("reset_status: the STATUS read raised pslverr");
            errors++;
        end
        apb_read(32'h020, rd, err);
        if (!err) begin
            $display("reset_status: a read from unmapped offset 0x020 gave no pslverr");
            errors++;
        end
        finish_test("reset_status");

        run_gemm("single_k5", random_base(), random_base(), 5, 1'b0);
        finish_test("single_k5");

        throttle = 1'b1; // Random ready and latency from here on.
        run_gemm("backpressure_k8", random_base(), random_base(), 8, 1'b0);
        finish_test("backpressure_k8");

        for (int r = 0; r < 3; r++) begin
            stim_rng = xorshift(stim_rng);
            k = 1 + int'(stim_rng % 12);
            run_gemm($sformatf("back_to_back_%0d", r), random_base(), random_base(), k, 1'b0);
            finish_test($sformatf("back_to_back_%0d", r));
        end

        run_gemm("start_while_busy", random_base(), random_base(), 6, 1'b1);
        finish_test("start_while_busy");

        run_gemm("empty_k0", random_base(), random_base(), 0, 1'b0);
        finish_test("empty_k0");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+src
src/gemm_pkg.sv
src/gemm_apb_regs.sv
src/gemm_tile_loader.sv
src/gemm_mac_row.sv
src/gemm_result_drain.sv
src/gemm_top.sv
tb/tb_clock_gen.sv
tb/tb_gemm_top.sv

//--- Bender.yml
package:
  name: gemm_tile

sources:
  - include_dirs:
      - src
    files:
      - src/gemm_pkg.sv
      - src/gemm_apb_regs.sv
      - src/gemm_tile_loader.sv
      - src/gemm_mac_row.sv
      - src/gemm_result_drain.sv
      - src/gemm_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_gemm_top.sv
